/* files.f */
hdl/bus_pkg.sv
hdl/timer_pkg.sv
hdl/timer_count.sv
hdl/timer_fsm.sv
hdl/timer_unit.sv
hdl/data_ram.sv
hdl/system_bridge.sv
hdl/mmio_subsystem.sv
verif/tb_mmio_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MMIO subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_mmio_subsystem -o sim_mmio
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_mmio > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if grep -qx "Simulation completed successfully" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

/* verif/tb_mmio_subsystem.sv */
`timescale 1ns/1ps

module tb_mmio_subsystem
    import bus_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst_n;
    bus_req_t    cpu_req;
    logic [31:0] cpu_rdata;
    logic [1:0]  irq;
    logic [31:0] int_ack_addr;
    logic [3:0]  int_ack_byteen;

    // Shadow state for the reference model
    logic [31:0] sh_ram [RAM_WORDS];
    logic        sh_known [RAM_WORDS];
    logic [3:0]  sh_ctrl [2];
    logic [31:0] sh_preset [2];
    logic        sh_count_known [2];

    // irq must read zero while set
    logic        irq_chk;

    int err_data;
    int err_ack;
    int err_irq;
    int err_time;

    mmio_subsystem UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_req        (cpu_req),
        .cpu_rdata      (cpu_rdata),
        .irq            (irq),
        .int_ack_addr   (int_ack_addr),
        .int_ack_byteen (int_ack_byteen)
    );

    // 20 ns period
    always #10 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic in_range(input logic [31:0] a, input logic [31:0] lo,
                                      input logic [31:0] hi);
        return (a >= lo) && (a <= hi);
    endfunction

    // Expected read data
    // Returns 0 when the value is not predictable
    function automatic logic ref_rdata(input bus_req_t req, output logic [31:0] exp_val);
        logic ok;
        int   t;
        ok = 1'b0;
        exp_val = 32'd0;
        if (in_range(req.addr, TC0_BASE, TC0_LAST) || in_range(req.addr, TC1_BASE, TC1_LAST)) begin
            t = in_range(req.addr, TC1_BASE, TC1_LAST) ? 1 : 0;
            case (req.addr[3:2])
                2'd0: begin
                    exp_val = {28'd0, sh_ctrl[t]};
                    ok = 1'b1;
                end
                2'd1: begin
                    exp_val = sh_preset[t];
                    ok = 1'b1;
                end
                default: begin
                    // COUNT holds its reset value until a timer runs
                    exp_val = 32'd0;
                    ok = sh_count_known[t];
                end
            endcase
        end else begin
            // RAM and ack region both read the RAM word
            exp_val = sh_ram[req.addr[11:2]];
            ok = sh_known[req.addr[11:2]];
        end
        return ok;
    endfunction

    // Apply one write to the shadow state
    function automatic void update_shadow(input bus_req_t req);
        int t;
        if (in_range(req.addr, TC0_BASE, TC0_LAST) || in_range(req.addr, TC1_BASE, TC1_LAST)) begin
            t = in_range(req.addr, TC1_BASE, TC1_LAST) ? 1 : 0;
            if (req.addr[3:2] == 2'd0) begin
                sh_ctrl[t] = req.wdata[3:0];
                // COUNT unpredictable once a timer runs
                if (req.wdata[0]) sh_count_known[t] = 1'b0;
            end else if (req.addr[3:2] == 2'd1) begin
                sh_preset[t] = req.wdata;
            end
        end else if (!in_range(req.addr, INT_BASE, INT_LAST)) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byteen[b]) sh_ram[req.addr[11:2]][8*b +: 8] = req.wdata[8*b +: 8];
            end
            if (req.byteen == 4'hf) sh_known[req.addr[11:2]] = 1'b1;
        end
    endfunction

    //////////////////////////////
    // Comparison
    //////////////////////////////

    // Sampled mid-cycle away from the driving edge
    always @(negedge clk) begin : compare
        logic [31:0] exp_rd;
        logic        known;
        logic        wr;
        logic [3:0]  exp_ack;
        wr = |cpu_req.byteen;
        exp_ack = (wr && in_range(cpu_req.addr, INT_BASE, INT_LAST)) ? 4'b0001 : 4'b0000;
        assert (int_ack_byteen == exp_ack) else begin
            $display("[ERROR] int_ack_byteen got=%h exp=%h", int_ack_byteen, exp_ack);
            err_ack++;
        end
        if (exp_ack != 4'b0000) begin
            assert (int_ack_addr == cpu_req.addr) else begin
                $display("[ERROR] int_ack_addr got=%h exp=%h", int_ack_addr, cpu_req.addr);
                err_ack++;
            end
        end
        if (!wr) begin
            known = ref_rdata(cpu_req, exp_rd);
            if (known) begin
                assert (cpu_rdata == exp_rd) else begin
                    $display("[ERROR] cpu_rdata addr=%h got=%h exp=%h",
                             cpu_req.addr, cpu_rdata, exp_rd);
                    err_data++;
                end
            end
        end
        if (irq_chk) begin
            assert (irq == 2'b00) else begin
                $display("[ERROR] irq got=%h exp=%h", irq, 2'b00);
                err_irq++;
            end
        end
        if (wr && rst_n) update_shadow(cpu_req);
    end

    //////////////////////////////
    // CPU bus driver
    //////////////////////////////

    // One-cycle write followed by idle
    task automatic bus_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        @(posedge clk);
        cpu_req <= '{addr: a, wdata: d, byteen: be};
        @(posedge clk);
        cpu_req <= '0;
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        @(posedge clk);
        cpu_req <= '{addr: a, wdata: 32'd0, byteen: 4'd0};
        @(negedge clk);
        d = cpu_rdata;
    endtask

    // Edges until irq bit is seen high
    // Gives -1 on timeout
    task automatic wait_irq(input int bit_no, input int limit, output int cycles);
        int n;
        n = 0;
        cycles = -1;
        while (n < limit) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (irq[bit_no]) begin
                cycles = n;
                break;
            end
        end
        if (cycles < 0) begin
            $display("Timeout waiting for irq bit %0d after %0d cycles", bit_no, limit);
            err_time++;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        logic [31:0] addrs[$];
        logic [31:0] io_addr [7];
        logic [31:0] r;
        logic [31:0] rd;
        logic [31:0] prev;
        int          p;
        int          n;
        rst_n = 1'b0;
        cpu_req = '0;
        irq_chk = 1'b1;
        err_data = 0;
        err_ack = 0;
        err_irq = 0;
        err_time = 0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            sh_ram[i] = 32'd0;
            sh_known[i] = 1'b0;
        end
        for (int t = 0; t < 2; t++) begin
            sh_ctrl[t] = 4'd0;
            sh_preset[t] = 32'd0;
            sh_count_known[t] = 1'b1;
        end
        void'($urandom(32'h8b4873ff));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Timer registers read zero after reset
        for (int k = 0; k < 3; k++) begin
            bus_read(TC0_BASE + 4 * k, rd);
            bus_read(TC1_BASE + 4 * k, rd);
        end

        // Full-word RAM writes followed by byte merges and read back
        for (int k = 0; k < 32; k++) begin
            r = $urandom_range(0, 32'h7efc);
            addrs.push_back(r & 32'hffff_fffc);
            bus_write(addrs[k], $urandom, 4'hf);
        end
        for (int k = 0; k < 48; k++) begin
            r = $urandom_range(1, 15);
            bus_write(addrs[$urandom_range(0, 31)], $urandom, r[3:0]);
        end
        foreach (addrs[i]) bus_read(addrs[i], rd);

        // I/O registers and the RAM words they alias
        io_addr = '{TC0_BASE, TC0_BASE + 4, TC0_BASE + 8,
                    TC1_BASE, TC1_BASE + 4, TC1_BASE + 8, INT_BASE};
        foreach (io_addr[i]) bus_write(io_addr[i] & 32'h0fff, $urandom, 4'hf);
        // Enable bit kept clear so no timer starts
        foreach (io_addr[i]) bus_write(io_addr[i], $urandom & 32'hffff_fffe, 4'hf);
        foreach (io_addr[i]) begin
            bus_read(io_addr[i] & 32'h0fff, rd);
            bus_read(io_addr[i], rd);
        end
        bus_write(TC0_BASE, 32'd0, 4'hf);
        bus_write(TC1_BASE, 32'd0, 4'hf);

        // Ack port strobes on every byte address
        for (int k = 0; k < 4; k++) begin
            r = $urandom_range(1, 15);
            bus_write(INT_BASE + k, $urandom, r[3:0]);
            bus_read(INT_BASE + k, rd);
        end
        bus_read(INT_BASE & 32'h0fff, rd);

        // One-shot on timer 0
        irq_chk = 1'b0;
        for (int k = 0; k < 3; k++) begin
            p = $urandom_range(1, 20);
            bus_write(TC0_BASE + 4, p, 4'hf);
            bus_write(TC0_BASE, 32'h9, 4'hf);
            wait_irq(0, p + 10, n);
            assert (n == p + 2) else begin
                $display("[ERROR] irq[0] delay got=%h exp=%h", n, p + 2);
                err_irq++;
            end
            repeat (4) begin
                @(negedge clk);
                assert (irq[0]) else begin
                    $display("[ERROR] irq[0] hold got=%h exp=%h", irq[0], 1'b1);
                    err_irq++;
                end
            end
            // Hardware cleared enable on the interrupt
            sh_ctrl[0][0] = 1'b0;
            bus_read(TC0_BASE, rd);
            bus_write(TC0_BASE, 32'h8, 4'hf);
            @(negedge clk);
            assert (!irq[0]) else begin
                $display("[ERROR] irq[0] after CTRL write got=%h exp=%h", irq[0], 1'b0);
                err_irq++;
            end
        end

        // Auto-reload on timer 1 with mask set
        p = $urandom_range(1, 20);
        bus_write(TC1_BASE + 4, p, 4'hf);
        bus_write(TC1_BASE, 32'hb, 4'hf);
        wait_irq(1, p + 10, n);
        assert (n == p + 2) else begin
            $display("[ERROR] irq[1] delay got=%h exp=%h", n, p + 2);
            err_irq++;
        end
        // Spacing of P+1 with P at least 1 also proves a one-cycle pulse
        for (int k = 0; k < 3; k++) begin
            wait_irq(1, p + 10, n);
            assert (n == p + 1) else begin
                $display("[ERROR] irq[1] spacing got=%h exp=%h", n, p + 1);
                err_irq++;
            end
        end

        // With mask clear COUNT keeps moving and no pulse appears
        bus_write(TC1_BASE, 32'h3, 4'hf);
        irq_chk = 1'b1;
        bus_read(TC1_BASE + 8, prev);
        for (int k = 0; k < 3 * (p + 1); k++) begin
            bus_read(TC1_BASE + 8, rd);
            assert (rd != prev) else begin
                $display("[ERROR] COUNT stalled got=%h prev=%h", rd, prev);
                err_data++;
            end
            prev = rd;
        end
        bus_write(TC1_BASE, 32'd0, 4'hf);
        repeat (4) @(posedge clk);

        $display("Errors: rdata %0d, ack %0d, irq %0d, timeout %0d",
                 err_data, err_ack, err_irq, err_time);
        if (err_data + err_ack + err_irq + err_time == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* hdl/mmio_subsystem.sv */
`timescale 1ns/1ps

module mmio_subsystem
    import bus_pkg::*;
    import timer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bus_req_t    cpu_req,
    output logic [31:0] cpu_rdata,
    output logic [1:0]  irq,
    output logic [31:0] int_ack_addr,
    output logic [3:0]  int_ack_byteen
);

    bus_req_t    ram_req;
    logic [31:0] ram_rdata;
    timer_acc_t  tc0_acc;
    timer_acc_t  tc1_acc;
    logic [31:0] tc0_rdata;
    logic [31:0] tc1_rdata;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    system_bridge u_bridge (
        .cpu_req        (cpu_req),
        .cpu_rdata      (cpu_rdata),
        .ram_req        (ram_req),
        .ram_rdata      (ram_rdata),
        .tc0_acc        (tc0_acc),
        .tc1_acc        (tc1_acc),
        .tc0_rdata      (tc0_rdata),
        .tc1_rdata      (tc1_rdata),
        .int_ack_addr   (int_ack_addr),
        .int_ack_byteen (int_ack_byteen)
    );

    data_ram u_ram (
        .clk   (clk),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

    // Timer 0 drives irq bit 0
    timer_unit u_tc0 (
        .clk   (clk),
        .rst_n (rst_n),
        .acc   (tc0_acc),
        .rdata (tc0_rdata),
        .irq   (irq[0])
    );

    timer_unit u_tc1 (
        .clk   (clk),
        .rst_n (rst_n),
        .acc   (tc1_acc),
        .rdata (tc1_rdata),
        .irq   (irq[1])
    );

endmodule

/* hdl/system_bridge.sv */
`timescale 1ns/1ps

module system_bridge
    import bus_pkg::*;
    import timer_pkg::*;
(
    input  bus_req_t    cpu_req,
    output logic [31:0] cpu_rdata,
    output bus_req_t    ram_req,
    input  logic [31:0] ram_rdata,
    output timer_acc_t  tc0_acc,
    output timer_acc_t  tc1_acc,
    input  logic [31:0] tc0_rdata,
    input  logic [31:0] tc1_rdata,
    output logic [31:0] int_ack_addr,
    output logic [3:0]  int_ack_byteen
);

    //////////////////////////////
    // Region decode
    //////////////////////////////

    logic in_tc0;
    logic in_tc1;
    logic in_int;
    logic is_write;

    // One compare per region, used by all steering below
    assign in_tc0   = (cpu_req.addr >= TC0_BASE) && (cpu_req.addr <= TC0_LAST);
    assign in_tc1   = (cpu_req.addr >= TC1_BASE) && (cpu_req.addr <= TC1_LAST);
    assign in_int   = (cpu_req.addr >= INT_BASE) && (cpu_req.addr <= INT_LAST);
    assign is_write = |cpu_req.byteen;

    //////////////////////////////
    // Timer accesses
    //////////////////////////////

    // Word offset inside the timer block
    assign tc0_acc.offset = cpu_req.addr[3:2];
    assign tc0_acc.wdata  = cpu_req.wdata;
    assign tc0_acc.we     = in_tc0 && is_write;

    assign tc1_acc.offset = cpu_req.addr[3:2];
    assign tc1_acc.wdata  = cpu_req.wdata;
    assign tc1_acc.we     = in_tc1 && is_write;

    //////////////////////////////
    // RAM and ack port
    //////////////////////////////

    assign ram_req.addr  = cpu_req.addr;
    assign ram_req.wdata = cpu_req.wdata;
    // No RAM write for any mapped I/O region
    assign ram_req.byteen = (in_tc0 || in_tc1 || in_int) ? 4'b0000 : cpu_req.byteen;

    // Ack strobe only while the CPU presents the write
    assign int_ack_addr   = cpu_req.addr;
    assign int_ack_byteen = (in_int && is_write) ? 4'b0001 : 4'b0000;

    // Read select, ack region falls through to RAM
    assign cpu_rdata = in_tc0 ? tc0_rdata :
                       in_tc1 ? tc1_rdata :
                                ram_rdata;

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram
    import bus_pkg::*;
(
    input  logic        clk,
    input  bus_req_t    req,
    output logic [31:0] rdata
);

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;

    // Word index from byte address
    assign idx = req.addr[RAM_AW+1:2];

    //////////////////////////////
    // Byte-lane write
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (req.byteen[b]) begin
                mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
    end

    // Asynchronous read, same cycle as the request
    assign rdata = mem[idx];

endmodule

/* hdl/timer_unit.sv */
`timescale 1ns/1ps

module timer_unit
    import timer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  timer_acc_t  acc,
    output logic [31:0] rdata,
    output logic        irq
);

    logic [CTRL_WIDTH-1:0] ctrl_q;
    logic [31:0]           preset_q;
    logic [31:0]           count;
    logic                  ctrl_write;
    logic                  load;
    logic                  dec;
    logic                  zero;
    logic                  irq_evt;
    logic                  clear_en;

    assign ctrl_write = acc.we && (acc.offset == CTRL_OFS);

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q   <= '0;
            preset_q <= 32'd0;
        end else begin
            // Software write wins over the one-shot enable clear
            if (ctrl_write) begin
                ctrl_q <= acc.wdata[CTRL_WIDTH-1:0];
            end else if (clear_en) begin
                ctrl_q[CTRL_EN_BIT] <= 1'b0;
            end
            if (acc.we && (acc.offset == PRESET_OFS)) begin
                preset_q <= acc.wdata;
            end
        end
    end

    // Register read, COUNT is read-only
    always_comb begin
        case (acc.offset)
            CTRL_OFS:   rdata = {{(32 - CTRL_WIDTH){1'b0}}, ctrl_q};
            PRESET_OFS: rdata = preset_q;
            COUNT_OFS:  rdata = count;
            default:    rdata = 32'd0;
        endcase
    end

    //////////////////////////////
    // Sequencer and counter
    //////////////////////////////

    timer_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (ctrl_q[CTRL_EN_BIT]),
        .mode       (timer_mode_e'(ctrl_q[CTRL_MODE_MSB:CTRL_MODE_LSB])),
        .ctrl_write (ctrl_write),
        .zero       (zero),
        .load       (load),
        .dec        (dec),
        .irq_evt    (irq_evt),
        .clear_en   (clear_en)
    );

    timer_count u_count (
        .clk    (clk),
        .rst_n  (rst_n),
        .load   (load),
        .preset (preset_q),
        .dec    (dec),
        .count  (count),
        .zero   (zero)
    );

    // Masked interrupt
    assign irq = irq_evt && ctrl_q[CTRL_IM_BIT];

endmodule

/* hdl/timer_fsm.sv */
`timescale 1ns/1ps

module timer_fsm
    import timer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  timer_mode_e mode,
    input  logic        ctrl_write,
    input  logic        zero,
    output logic        load,
    output logic        dec,
    output logic        irq_evt,
    output logic        clear_en
);

    timer_state_e state;
    timer_state_e state_nxt;
    logic         reload;

    // Any mode other than 1 behaves as one-shot
    assign reload = (mode == MODE_RELOAD);

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (enable) state_nxt = ST_LOAD;
            end
            ST_LOAD: begin
                state_nxt = enable ? ST_COUNT : ST_IDLE;
            end
            ST_COUNT: begin
                // Enable cleared, stop with COUNT frozen
                if (!enable)   state_nxt = ST_IDLE;
                else if (zero) state_nxt = ST_IRQ;
            end
            ST_IRQ: begin
                // Reload happens in the irq cycle itself
                if (reload)          state_nxt = enable ? ST_COUNT : ST_IDLE;
                // One-shot waits here for software
                else if (ctrl_write) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign load     = (state == ST_LOAD) || ((state == ST_IRQ) && reload && enable);
    assign dec      = (state == ST_COUNT) && enable;
    assign irq_evt  = (state == ST_IRQ);
    // One-shot drops enable on the edge into ST_IRQ
    assign clear_en = (state == ST_COUNT) && enable && zero && !reload;

endmodule

/* hdl/timer_count.sv */
`timescale 1ns/1ps

module timer_count (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load,
    input  logic [31:0] preset,
    input  logic        dec,
    output logic [31:0] count,
    output logic        zero
);

    logic at_zero;

    // Never wrap below zero
    assign at_zero = (count == 32'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= 32'd0;
        end else if (load) begin
            count <= preset;
        end else if (dec && !at_zero) begin
            count <= count - 32'd1;
        end
    end

    // Next decrement lands on zero
    // Covers a count of 1 and a count already at 0
    assign zero = (count[31:1] == 31'd0);

endmodule

/* hdl/timer_pkg.sv */
package timer_pkg;

    // Timer FSM states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_LOAD  = 2'd1,
        ST_COUNT = 2'd2,
        ST_IRQ   = 2'd3
    } timer_state_e;

    // Counting modes, 2-bit field in CTRL
    typedef enum logic [1:0] {
        MODE_ONESHOT = 2'd0,
        MODE_RELOAD  = 2'd1
    } timer_mode_e;

    // Register word offsets
    localparam logic [1:0] CTRL_OFS   = 2'd0;
    localparam logic [1:0] PRESET_OFS = 2'd1;
    localparam logic [1:0] COUNT_OFS  = 2'd2;

    // CTRL field positions
    localparam int CTRL_EN_BIT   = 0;
    localparam int CTRL_MODE_LSB = 1;
    localparam int CTRL_MODE_MSB = 2;
    localparam int CTRL_IM_BIT   = 3;
    localparam int CTRL_WIDTH    = 4;

    // Register access from the bridge
    typedef struct packed {
        logic [1:0]  offset;
        logic [31:0] wdata;
        logic        we;
    } timer_acc_t;

endpackage

/* hdl/bus_pkg.sv */
package bus_pkg;

    //////////////////////////////
    // Address map
    //////////////////////////////

    // Timer 0 registers
    localparam logic [31:0] TC0_BASE = 32'h0000_7f00;
    localparam logic [31:0] TC0_LAST = 32'h0000_7f0b;

    // Timer 1 registers
    localparam logic [31:0] TC1_BASE = 32'h0000_7f10;
    localparam logic [31:0] TC1_LAST = 32'h0000_7f1b;

    // Interrupt acknowledge port
    localparam logic [31:0] INT_BASE = 32'h0000_7f20;
    localparam logic [31:0] INT_LAST = 32'h0000_7f23;

    //////////////////////////////
    // Data RAM
    //////////////////////////////

    // Depth in 32-bit words
    localparam int RAM_WORDS = 1024;
    // Word index width, index taken from addr[11:2]
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    // CPU data port request
    // Nonzero byteen marks a write
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byteen;
    } bus_req_t;

endpackage
